// ==== vlog.f ====
+incdir+logic
logic/isaPkg.sv
logic/robPkg.sv
logic/oooIfc.sv
logic/regRename.sv
logic/aluStation.sv
logic/reorderBuffer.sv
logic/oooCore.sv
bench/clkGen.sv
bench/oooCore_sva.sv
bench/oooChecker.sv
bench/oooCore_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the oooCore testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module oooCore_tb -o oooCoreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/oooCoreSim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "All tests passed!"; then
    exit 0
fi
exit 1

// ==== bench/oooCore_tb.sv ====
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module oooCore_tb;
    localparam int NumDirected = 9;
    localparam int NumRandom   = 160;
    localparam int NumBurst    = 20;
    localparam int CycleLimit  = 20 * (NumDirected + NumRandom + NumBurst) + 10;

    localparam int KAdd  = 0;
    localparam int KSub  = 1;
    localparam int KOr   = 3;
    localparam int KSll  = 5;
    localparam int KAddi = 7;
    localparam int KXori = 10;
    localparam int KLui  = 11;

    logic             clk;
    logic             rst;
    logic             instValid;
    logic [31:0]      instWord;
    logic             instReady;
    logic             commitValid;
    logic [4:0]       commitRd;
    logic [`XLEN-1:0] commitData;
    logic             burst;
    logic             endReq;
    int               outstanding;
    logic             reported;
    int               errorCount;
    int               cycles = 0;
    integer           seed = 32'h2854;

    clkGen clockSrc (.clk(clk), .rst(rst));

    oooCore u_oooCore (
        .clk         (clk),
        .rst         (rst),
        .instValid   (instValid),
        .instWord    (instWord),
        .instReady   (instReady),
        .commitValid (commitValid),
        .commitRd    (commitRd),
        .commitData  (commitData)
    );

    oooChecker resultCheck (
        .clk (clk), .rst (rst), .instValid (instValid), .instWord (instWord),
        .instReady (instReady), .commitValid (commitValid), .commitRd (commitRd),
        .commitData (commitData), .burst (burst), .endReq (endReq),
        .outstanding (outstanding), .reported (reported), .errorCount (errorCount)
    );

    bind oooCore oooCore_sva assertChecks (
        .clk (clk), .rst (rst), .instValid (instValid), .instWord (instWord),
        .instReady (instReady), .commitValid (commitValid), .commitRd (commitRd),
        .commitData (commitData)
    );

    // RV32I encodings of the kept operations, kind 0 to 11.
    function automatic logic [31:0] makeInst(input int kind, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [19:0] imm);
        case (kind)
            0:       return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            1:       return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            2:       return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            3:       return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            4:       return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            5:       return {7'b0000000, rs2, rs1, 3'b001, rd, 7'b0110011};
            6:       return {7'b0000000, rs2, rs1, 3'b101, rd, 7'b0110011};
            7:       return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            8:       return {imm[11:0], rs1, 3'b111, rd, 7'b0010011};
            9:       return {imm[11:0], rs1, 3'b110, rd, 7'b0010011};
            10:      return {imm[11:0], rs1, 3'b100, rd, 7'b0010011};
            default: return {imm, rd, 7'b0110111};
        endcase
    endfunction

    // Registers x0 to x7 only, so dependencies are dense.
    task automatic drawRandomInst(output logic [31:0] w);
        logic [31:0] r;
        logic [31:0] imm;
        r   = $random(seed);
        imm = $random(seed);
        w   = makeInst(int'(r[31:16]) % 12, {2'b00, r[2:0]}, {2'b00, r[5:3]},
                       {2'b00, r[8:6]}, imm[19:0]);
    endtask

    // Called on a falling edge; holds the word until a rising edge takes it.
    task automatic sendInst(input logic [31:0] w);
        logic taken;
        instValid = 1'b1;
        instWord  = w;
        taken     = 1'b0;
        while (!taken) begin
            taken = instReady;    // Stable between rising edges.
            @(negedge clk);
        end
        instValid = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        logic [31:0] w;
        logic [31:0] gap;
        instValid = 1'b0;
        instWord  = '0;
        burst     = 1'b0;
        endReq    = 1'b0;
        wait (!rst);
        repeat (4) @(negedge clk);    // Idle, no commits expected.

        sendInst(makeInst(KAddi, 5'd1, 5'd0, 5'd0, 20'h007ff));
        sendInst(makeInst(KLui, 5'd2, 5'd0, 5'd0, 20'h80001));
        sendInst(makeInst(KAddi, 5'd3, 5'd0, 5'd0, 20'hffffd));
        sendInst(makeInst(KAdd, 5'd4, 5'd1, 5'd2, 20'h0));
        sendInst(makeInst(KSub, 5'd4, 5'd4, 5'd3, 20'h0));    // x4 written twice.
        sendInst(makeInst(KSll, 5'd6, 5'd1, 5'd3, 20'h0));
        sendInst(makeInst(KXori, 5'd7, 5'd2, 5'd0, 20'h00555));
        sendInst(makeInst(KAddi, 5'd0, 5'd1, 5'd0, 20'h00005));
        sendInst(makeInst(KOr, 5'd7, 5'd0, 5'd1, 20'h0));

        for (int i = 0; i < NumRandom; i++) begin
            drawRandomInst(w);
            sendInst(w);
            gap = $random(seed);
            repeat (gap[1:0] & {1'b0, gap[2]}) @(negedge clk);
        end

        // Long chain on x5 fills the stations.
        burst = 1'b1;
        for (int i = 0; i < NumBurst; i++) begin
            sendInst(makeInst((i % 2 == 0) ? KAddi : KAdd, 5'd5, 5'd5, 5'd5, 20'(i + 1)));
        end
        burst = 1'b0;

        while (outstanding != 0) @(negedge clk);
        repeat (4) @(negedge clk);    // Window for stray commits.
        endReq = 1'b1;
        while (!reported) @(negedge clk);

        if (errorCount == 0 && u_oooCore.assertChecks.failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end
endmodule

// ==== bench/oooChecker.sv ====
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module oooChecker (
    input  logic             clk,
    input  logic             rst,
    input  logic             instValid,
    input  logic [31:0]      instWord,
    input  logic             instReady,
    input  logic             commitValid,
    input  logic [4:0]       commitRd,
    input  logic [`XLEN-1:0] commitData,
    input  logic             burst,
    input  logic             endReq,
    output int               outstanding,
    output logic             reported,
    output int               errorCount
);
    logic [31:0]      pending [$];    // Accepted words in program order.
    logic [`XLEN-1:0] model   [32];
    logic [31:0]      w;
    logic [4:0]       expRd;
    logic [`XLEN-1:0] expData;
    int               commitCount = 0;
    int               valueErrors = 0;
    int               orderErrors = 0;
    int               missing     = 0;
    int               stallCount  = 0;

    // Sequential RV32I semantics of one instruction.
    function automatic logic [`XLEN-1:0] refExec(input logic [31:0] iw,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        logic [`XLEN-1:0] immI;
        immI = {{20{iw[31]}}, iw[31:20]};
        if (iw[6:0] == 7'b0110111) begin
            return {iw[31:12], 12'b0};
        end
        if (iw[6:0] == 7'b0010011) begin
            case (iw[14:12])
                3'b100:  return a ^ immI;
                3'b110:  return a | immI;
                3'b111:  return a & immI;
                default: return a + immI;
            endcase
        end
        case (iw[14:12])
            3'b000:  return iw[30] ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    initial begin
        outstanding = 0;
        reported    = 1'b0;
        errorCount  = 0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (commitValid && pending.size() == 0) begin
                orderErrors++;
                $display("%0t: commit to x%0d with no accepted instruction outstanding",
                         $time, commitRd);
            end else if (commitValid) begin
                w       = pending.pop_front();
                expRd   = w[11:7];
                expData = (expRd == 0) ? '0 : refExec(w, model[w[19:15]], model[w[24:20]]);
                if (commitRd !== expRd || commitData !== expData) begin
                    valueErrors++;
                    $display("CHECK FAILED at %0t: commit %0d gave x%0d = %h, expected x%0d = %h",
                             $time, commitCount, commitRd, commitData, expRd, expData);
                end
                if (expRd != 0) begin
                    model[expRd] = expData;
                end
                commitCount++;
            end
            if (instValid && instReady) begin
                pending.push_back(instWord);
            end
            if (burst && instValid && !instReady) begin
                stallCount++;
            end
            outstanding = pending.size();
        end
        if (endReq && !reported) begin
            missing = pending.size();
            if (missing != 0) begin
                $display("%0d accepted instructions never committed", missing);
            end
            if (stallCount == 0) begin
                orderErrors++;
                $display("instReady never dropped during the dependency burst");
            end
            $display("Commits checked: %0d, value errors: %0d, order errors: %0d, missing: %0d",
                     commitCount, valueErrors, orderErrors, missing);
            errorCount = valueErrors + orderErrors + missing;
            reported   = 1'b1;
        end
    end
endmodule

// ==== bench/oooCore_sva.sv ====
`timescale 1ns/1ns

module oooCore_sva (
    input logic        clk,
    input logic        rst,
    input logic        instValid,
    input logic [31:0] instWord,
    input logic        instReady,
    input logic        commitValid,
    input logic [4:0]  commitRd,
    input logic [31:0] commitData
);
    int failCount = 0;

    resetQuiet: assert property (@(posedge clk) rst && $past(rst) |-> !instReady && !commitValid)
        else begin
            failCount++;
            $error("instReady or commitValid high during reset");
        end

    zeroRegData: assert property (@(posedge clk) disable iff (rst)
        commitValid && commitRd == 5'd0 |-> commitData == '0)
        else begin
            failCount++;
            $error("commit to x0 carried nonzero data");
        end

    holdWhileWaiting: assert property (@(posedge clk) disable iff (rst)
        instValid && !instReady |=> instValid && $stable(instWord))
        else begin
            failCount++;
            $error("instruction changed or dropped while waiting for instReady");
        end
endmodule

// ==== bench/clkGen.sv ====
`timescale 1ns/1ns

module clkGen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;    // 20 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);    // Release away from the active edge.
        rst = 1'b0;
    end
endmodule

// ==== logic/oooCore.sv ====
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module oooCore (
    input  logic             clk,
    input  logic             rst,
    input  logic             instValid,
    input  logic [31:0]      instWord,
    output logic             instReady,
    output logic             commitValid,
    output logic [4:0]       commitRd,
    output logic [`XLEN-1:0] commitData
);
    logic [`TAG_W-1:0] freeTag;
    logic              allocOk;
    logic              allocEn;
    logic [4:0]        allocRd;
    logic [`TAG_W-1:0] commitTag;

    dispatchIfc dispBus ();
    resultIfc   resBus ();

    // Accepted instruction claims the tail entry.
    assign allocEn = instValid && instReady;
    assign allocRd = instWord[11:7];

    regRename u_regRename (
        .clk        (clk),
        .rst        (rst),
        .instValid  (instValid),
        .instWord   (instWord),
        .instReady  (instReady),
        .freeTag    (freeTag),
        .allocOk    (allocOk),
        .disp       (dispBus.source),
        .res        (resBus.listener),
        .commitEn   (commitValid),
        .commitRd   (commitRd),
        .commitTag  (commitTag),
        .commitData (commitData)
    );

    for (genvar s = 0; s < `NUM_STATIONS; s++) begin : gStation
        aluStation #(
            .stationId (s)
        ) u_aluStation (
            .clk  (clk),
            .rst  (rst),
            .disp (dispBus.sink),
            .res  (resBus.station)
        );
    end

    reorderBuffer u_reorderBuffer (
        .clk        (clk),
        .rst        (rst),
        .res        (resBus.arbiter),
        .freeTag    (freeTag),
        .allocOk    (allocOk),
        .allocEn    (allocEn),
        .allocRd    (allocRd),
        .commitEn   (commitValid),
        .commitRd   (commitRd),
        .commitTag  (commitTag),
        .commitData (commitData)
    );

endmodule

// ==== logic/reorderBuffer.sv ====
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module reorderBuffer import robPkg::*; (
    input  logic             clk,
    input  logic             rst,
    resultIfc.arbiter        res,
    output tagT              freeTag,
    output logic             allocOk,
    input  logic             allocEn,
    input  logic [4:0]       allocRd,
    output logic             commitEn,
    output logic [4:0]       commitRd,
    output tagT              commitTag,
    output logic [`XLEN-1:0] commitData
);
    localparam int StW = $clog2(`NUM_STATIONS);

    logic [RobIdxW-1:0] head;
    logic [RobIdxW-1:0] tail;
    logic [RobIdxW:0]   count;
    logic [4:0]         entRd   [`ROB_DEPTH];
    logic [`XLEN-1:0]   entVal  [`ROB_DEPTH];
    logic               entDone [`ROB_DEPTH];
    logic [StW-1:0]     rrPtr;
    logic [StW-1:0]     grantIdx;
    logic               found;
    resultT             winner;
    logic [RobIdxW-1:0] winIdx;
    logic               retire;

    function automatic logic [RobIdxW-1:0] nextIdx(input logic [RobIdxW-1:0] i);
        return (i == RobIdxW'(`ROB_DEPTH - 1)) ? '0 : i + 1'b1;
    endfunction

    assign allocOk = count < (RobIdxW+1)'(`ROB_DEPTH);
    assign freeTag = tagT'(tail) + tagT'(1);    // Entry i carries tag i+1.
    assign retire  = (count != '0) && entDone[head];

    // Round-robin search starting at rrPtr.
    always_comb begin
        int cand;
        found     = 1'b0;
        grantIdx  = '0;
        res.grant = '0;
        for (int k = 0; k < `NUM_STATIONS; k++) begin
            cand = (int'(rrPtr) + k) % `NUM_STATIONS;
            if (!found && res.req[cand]) begin
                found    = 1'b1;
                grantIdx = StW'(cand);
            end
        end
        if (found) begin
            res.grant[grantIdx] = 1'b1;
        end
    end

    assign winner = res.stationRes[grantIdx];
    assign winIdx = tagIdx(winner.tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            rrPtr       <= '0;
            res.bcValid <= 1'b0;
            commitEn    <= 1'b0;
            for (int e = 0; e < `ROB_DEPTH; e++) begin
                entDone[e] <= 1'b0;
            end
        end else begin
            res.bcValid <= found;
            commitEn    <= retire;
            if (allocEn) begin
                entDone[tail] <= 1'b0;
                tail          <= nextIdx(tail);
            end
            if (found) begin
                entDone[winIdx] <= 1'b1;    // Done as the broadcast starts.
                rrPtr <= (grantIdx == StW'(`NUM_STATIONS - 1)) ? '0 : grantIdx + 1'b1;
            end
            if (retire) begin
                head <= nextIdx(head);
            end
            case ({allocEn, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (allocEn) begin
            entRd[tail] <= allocRd;
        end
        if (found) begin
            entVal[winIdx] <= winner.value;
            res.bcRes      <= winner;
        end
        if (retire) begin
            commitRd   <= entRd[head];
            commitTag  <= tagT'(head) + tagT'(1);
            commitData <= (entRd[head] == '0) ? '0 : entVal[head];    // x0 stays zero.
        end
    end

endmodule

// ==== logic/aluStation.sv ====
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module aluStation import isaPkg::*, robPkg::*; #(
    parameter int stationId = 0
) (
    input  logic      clk,
    input  logic      rst,
    dispatchIfc.sink  disp,
    resultIfc.station res
);
    logic             valid;
    logic             req;
    aluOpT            op;
    operandT          opA;
    operandT          opB;
    tagT              destTag;
    logic [`XLEN-1:0] resVal;
    logic             ready;
    logic             hitA;
    logic             hitB;

    function automatic logic [`XLEN-1:0] aluCalc(
        input aluOpT            f,
        input logic [`XLEN-1:0] a,
        input logic [`XLEN-1:0] b
    );
        case (f)
            AluSub:  return a - b;
            AluAnd:  return a & b;
            AluOr:   return a | b;
            AluXor:  return a ^ b;
            AluSll:  return a << b[$clog2(`XLEN)-1:0];
            AluSrl:  return a >> b[$clog2(`XLEN)-1:0];
            default: return a + b;
        endcase
    endfunction

    assign ready = valid && opA.tag == '0 && opB.tag == '0;
    assign hitA  = res.bcValid && opA.tag != '0 && res.bcRes.tag == opA.tag;
    assign hitB  = res.bcValid && opB.tag != '0 && res.bcRes.tag == opB.tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            req   <= 1'b0;
        end else if (disp.valid[stationId]) begin
            valid <= 1'b1;
            req   <= 1'b0;
        end else if (req && res.grant[stationId]) begin
            valid <= 1'b0;    // Result is on its way to the bus.
            req   <= 1'b0;
        end else if (ready) begin
            req <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (disp.valid[stationId]) begin
            op      <= disp.payload.aluOp;
            opA     <= disp.payload.src1;
            opB     <= disp.payload.src2;
            destTag <= disp.payload.destTag;
        end else begin
            if (hitA) begin
                opA <= '{value: res.bcRes.value, tag: '0};
            end
            if (hitB) begin
                opB <= '{value: res.bcRes.value, tag: '0};
            end
            if (ready && !req) begin
                resVal <= aluCalc(op, opA.value, opB.value);
            end
        end
    end

    assign disp.busy[stationId]      = valid;
    assign res.req[stationId]        = req;
    assign res.stationRes[stationId] = '{tag: destTag, value: resVal};

endmodule

// ==== logic/regRename.sv ====
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module regRename import isaPkg::*, robPkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             instValid,
    input  instWordU         instWord,
    output logic             instReady,
    input  tagT              freeTag,
    input  logic             allocOk,
    dispatchIfc.source       disp,
    resultIfc.listener       res,
    input  logic             commitEn,
    input  logic [4:0]       commitRd,
    input  tagT              commitTag,
    input  logic [`XLEN-1:0] commitData
);
    logic [`XLEN-1:0]         regVal  [`REG_NUM];
    tagT                      regTag  [`REG_NUM];
    logic                     tagDone [`ROB_DEPTH];
    logic [`XLEN-1:0]         tagVal  [`ROB_DEPTH];
    logic                     live;
    logic                     accept;
    logic [`NUM_STATIONS-1:0] freeVec;
    logic [`NUM_STATIONS-1:0] firstFree;
    logic [4:0]               rdIdx;

    // Value or pending tag, with broadcast and finished-tag bypass.
    function automatic operandT readOperand(input logic [4:0] idx);
        operandT op;
        op.value = regVal[idx];
        op.tag   = regTag[idx];
        if (op.tag != '0) begin
            if (res.bcValid && res.bcRes.tag == op.tag) begin
                op.value = res.bcRes.value;
                op.tag   = '0;
            end else if (tagDone[tagIdx(op.tag)]) begin
                op.value = tagVal[tagIdx(op.tag)];
                op.tag   = '0;
            end
        end
        return op;
    endfunction

    assign rdIdx     = instWord.r.rd;
    assign freeVec   = ~disp.busy;
    assign firstFree = freeVec & (~freeVec + 1'b1);
    assign instReady = live && allocOk && (|freeVec);
    assign accept    = instValid && instReady;
    assign disp.valid = accept ? firstFree : '0;

    always_comb begin
        disp.payload.aluOp   = AluAdd;
        disp.payload.src1    = readOperand(instWord.r.rs1);
        disp.payload.src2    = readOperand(instWord.r.rs2);
        disp.payload.destTag = freeTag;
        disp.payload.rd      = rdIdx;
        case (instWord.r.opcode)
            OpcOp: begin
                case (instWord.r.funct3)
                    F3AddSub: disp.payload.aluOp = instWord.r.funct7[5] ? AluSub : AluAdd;
                    F3Sll:    disp.payload.aluOp = AluSll;
                    F3Xor:    disp.payload.aluOp = AluXor;
                    F3Srl:    disp.payload.aluOp = AluSrl;
                    F3Or:     disp.payload.aluOp = AluOr;
                    F3And:    disp.payload.aluOp = AluAnd;
                    default:  disp.payload.aluOp = AluAdd;
                endcase
            end
            OpcOpImm: begin
                disp.payload.src2 = '{value: {{(`XLEN-12){instWord.i.imm12[11]}},
                                              instWord.i.imm12},
                                      tag: '0};
                case (instWord.i.funct3)
                    F3Xor:   disp.payload.aluOp = AluXor;
                    F3Or:    disp.payload.aluOp = AluOr;
                    F3And:   disp.payload.aluOp = AluAnd;
                    default: disp.payload.aluOp = AluAdd;
                endcase
            end
            OpcLui: begin
                disp.payload.src1 = '{value: '0, tag: '0};    // 0 + upper immediate.
                disp.payload.src2 = '{value: {instWord.i.imm12, instWord.i.rs1,
                                              instWord.i.funct3, 12'b0},
                                      tag: '0};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            live <= 1'b0;
            for (int r = 0; r < `REG_NUM; r++) begin
                regVal[r] <= '0;
                regTag[r] <= '0;
            end
            for (int t = 0; t < `ROB_DEPTH; t++) begin
                tagDone[t] <= 1'b0;
            end
        end else begin
            live <= 1'b1;
            // Only the newest producer may clear the tag.
            if (commitEn && regTag[commitRd] == commitTag) begin
                regVal[commitRd] <= commitData;
                regTag[commitRd] <= '0;
            end
            if (res.bcValid) begin
                tagDone[tagIdx(res.bcRes.tag)] <= 1'b1;
            end
            if (accept) begin
                tagDone[tagIdx(freeTag)] <= 1'b0;
                if (rdIdx != '0) begin
                    regTag[rdIdx] <= freeTag;    // Overrides a same-edge commit.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res.bcValid) begin
            tagVal[tagIdx(res.bcRes.tag)] <= res.bcRes.value;
        end
    end

endmodule

// ==== logic/oooIfc.sv ====
`timescale 1ns/1ns
`include "ooo_cfg.svh"

interface dispatchIfc import robPkg::*; ();
    logic [`NUM_STATIONS-1:0] valid;    // One-hot, lowest free station.
    dispatchT                 payload;
    logic [`NUM_STATIONS-1:0] busy;

    modport source (
        output valid,
        output payload,
        input  busy
    );

    modport sink (
        input  valid,
        input  payload,
        output busy
    );
endinterface

interface resultIfc import robPkg::*; ();
    logic   [`NUM_STATIONS-1:0] req;
    resultT [`NUM_STATIONS-1:0] stationRes;
    logic   [`NUM_STATIONS-1:0] grant;
    logic                       bcValid;    // Common result bus.
    resultT                     bcRes;

    modport station (
        output req,
        output stationRes,
        input  grant,
        input  bcValid,
        input  bcRes
    );

    modport arbiter (
        input  req,
        input  stationRes,
        output grant,
        output bcValid,
        output bcRes
    );

    modport listener (
        input bcValid,
        input bcRes
    );
endinterface

// ==== logic/robPkg.sv ====
`include "ooo_cfg.svh"

package robPkg;
    import isaPkg::*;

    localparam int RobIdxW = $clog2(`ROB_DEPTH);

    typedef logic [`TAG_W-1:0] tagT;

    typedef struct packed {
        logic [`XLEN-1:0] value;
        tagT              tag;    // Ready when zero.
    } operandT;

    typedef struct packed {
        aluOpT      aluOp;
        operandT    src1;
        operandT    src2;
        tagT        destTag;
        logic [4:0] rd;
    } dispatchT;

    typedef struct packed {
        tagT              tag;
        logic [`XLEN-1:0] value;
    } resultT;

    // Entry index of a nonzero tag.
    function automatic logic [RobIdxW-1:0] tagIdx(input tagT t);
        return RobIdxW'(t - tagT'(1));
    endfunction

endpackage

// ==== logic/isaPkg.sv ====
package isaPkg;

    typedef enum logic [6:0] {
        OpcOp    = 7'b0110011,
        OpcOpImm = 7'b0010011,
        OpcLui   = 7'b0110111
    } opcodeT;

    typedef enum logic [3:0] {
        AluAdd = 4'd0,
        AluSub = 4'd1,
        AluAnd = 4'd2,
        AluOr  = 4'd3,
        AluXor = 4'd4,
        AluSll = 4'd5,
        AluSrl = 4'd6
    } aluOpT;

    localparam logic [2:0] F3AddSub = 3'b000;
    localparam logic [2:0] F3Sll    = 3'b001;
    localparam logic [2:0] F3Xor    = 3'b100;
    localparam logic [2:0] F3Srl    = 3'b101;
    localparam logic [2:0] F3Or     = 3'b110;
    localparam logic [2:0] F3And    = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcodeT     opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcodeT      opcode;
    } iTypeT;

    // LUI upper field is imm12, rs1 and funct3 of the I view.
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instWordU;

endpackage

// ==== logic/ooo_cfg.svh ====
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// Data path width.
`define XLEN 32

// Architectural registers x0 to x31.
`define REG_NUM 32

// Reorder buffer entries, tagged 1 to ROB_DEPTH.
`define ROB_DEPTH 8

// Tag 0 is reserved for "no producer", so one extra bit.
`define TAG_W 4

// Identical ALU reservation stations.
`define NUM_STATIONS 4

`endif
